// ==== build.f ====
+incdir+source
source/raster_pkg.sv
source/raster_if.sv
source/raster_reg_decode.sv
source/raster_engine.sv
source/scan_timing.sv
source/frame_store.sv
source/line_raster_top.sv
sim/raster_sva.sv
sim/tb_line_raster.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the line raster testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_line_raster -o tb_line_raster

./obj_dir/tb_line_raster | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log
echo "simulation finished without failures"

// ==== sim/tb_line_raster.sv ====
/* directed testbench for the line raster subsystem: AXI4-Lite register
   tasks, frame capture and a shadow frame model */
`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module tb_line_raster;

    localparam int W     = `RASTER_WIDTH;
    localparam int H     = `RASTER_HEIGHT;
    localparam int LIMIT = 2000;                        // cycles per wait
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        clk_pix, arst_n;
    logic [31:0] awaddr, wdata, araddr;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [31:0] rdata;
    logic [3:0]  pix_cidx;
    logic        pix_de, pix_hsync, pix_vsync;

    logic [3:0]  shadow [W*H];                          // expected picture
    logic [3:0]  cap [W*H];                             // captured picture
    logic [3:0]  clear_col;
    int          errors, checks;

    line_raster_top i_dut (.*);

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    function automatic logic [31:0] coord_word(input int x, input int y);
        return {16'h0, 8'(y), 8'(x)};
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [1:0] op, input logic [3:0] c);
        return {26'h0, op, c};
    endfunction

    // any colour except c
    function automatic logic [3:0] other_colour(input logic [3:0] c);
        return c + 4'($urandom_range(15, 1));
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        @(negedge clk_pix);
        while (!awready && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (!awready)
            report_timeout("the write address handshake");
        check_equal(wready, 1'b1, "wready alongside awready");
        @(posedge clk_pix);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        @(negedge clk_pix);
        while (!bvalid && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (!bvalid)
            report_timeout("the write response");
        resp = bresp;
        @(posedge clk_pix);                             // response waits one cycle
        #2;
        bready = 1'b1;
        @(posedge clk_pix);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clk_pix);
        while (!arready && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (!arready)
            report_timeout("the read address handshake");
        @(posedge clk_pix);
        #2;
        arvalid = 1'b0;
        n = 0;
        @(negedge clk_pix);
        while (!rvalid && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (!rvalid)
            report_timeout("the read data");
        data = rdata;
        resp = rresp;
        @(posedge clk_pix);                             // data waits one cycle
        #2;
        rready = 1'b1;
        @(posedge clk_pix);
        #2;
        rready = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] data;
        logic [1:0]  resp;
        int          n;
        n = 0;
        axi_read(`RASTER_ADDR_STATUS, data, resp);
        while (data[0] !== 1'b0 && n < LIMIT) begin
            axi_read(`RASTER_ADDR_STATUS, data, resp);
            n++;
        end
        if (data[0] !== 1'b0)
            report_timeout("the engine to finish");
    endtask

    task automatic run_op(input logic [1:0] op, input logic [3:0] c);
        logic [1:0] resp;
        axi_write(`RASTER_ADDR_CTRL, ctrl_word(op, c), resp);
        check_equal(resp, OKAY, "CTRL write response");
        wait_idle();
    endtask

    task automatic capture_frame();
        int n;
        int idx;
        n = 0;
        @(negedge clk_pix);
        while (!pix_vsync && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (!pix_vsync)
            report_timeout("vsync");
        n   = 0;
        idx = 0;
        while (idx < W*H && n < LIMIT) begin
            @(negedge clk_pix);
            if (pix_de) begin
                cap[idx] = pix_cidx;
                idx++;
            end
            n++;
        end
        if (idx < W*H)
            report_timeout("the active pixels of a frame");
        @(posedge clk_pix);
        #2;
    endtask

    // vsync spans one whole line with the hsync pulse inside it
    task automatic verify_sync_timing();
        int n;
        int hs_first;
        int hs_count;
        n = 0;
        @(negedge clk_pix);
        while (pix_vsync && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        n = 0;
        while (!pix_vsync && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (!pix_vsync)
            report_timeout("vsync");
        n        = 0;
        hs_first = -1;
        hs_count = 0;
        while (pix_vsync && n < LIMIT) begin
            if (pix_hsync) begin
                if (hs_first < 0)
                    hs_first = n;
                hs_count++;
            end
            @(negedge clk_pix);
            n++;
        end
        check_equal(n, `RASTER_H_TOTAL, "vsync width in cycles");
        check_equal(hs_first, `RASTER_HS_START, "hsync start column");
        check_equal(hs_count, `RASTER_HS_END - `RASTER_HS_START + 1,
                    "hsync width in cycles");
        @(posedge clk_pix);
        #2;
    endtask

    task automatic compare_frame(input string what);
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                check_equal(cap[y*W+x], shadow[y*W+x],
                            $sformatf("%s pixel (%0d,%0d)", what, x, y));
    endtask

    task automatic fill_shadow(input logic [3:0] c);
        for (int i = 0; i < W*H; i++)
            shadow[i] = c;
    endtask

    // straight and 45 degree lines only; off-frame pixels dropped
    task automatic shadow_line(input int x0, input int y0, input int x1, input int y1,
                               input logic [3:0] c);
        int steps;
        int sx;
        int sy;
        int x;
        int y;
        sx    = (x1 > x0) ? 1 : (x1 < x0) ? -1 : 0;
        sy    = (y1 > y0) ? 1 : (y1 < y0) ? -1 : 0;
        steps = (x1 - x0) * sx;
        if ((y1 - y0) * sy > steps)
            steps = (y1 - y0) * sy;
        for (int i = 0; i <= steps; i++) begin
            x = x0 + i * sx;
            y = y0 + i * sy;
            if (x >= 0 && x < W && y >= 0 && y < H)
                shadow[y*W+x] = c;
        end
    endtask

    task automatic draw_line(input int x0, input int y0, input int x1, input int y1);
        logic [1:0] resp;
        logic [3:0] c;
        c = other_colour(clear_col);
        axi_write(`RASTER_ADDR_P0, coord_word(x0, y0), resp);
        check_equal(resp, OKAY, "P0 write response");
        axi_write(`RASTER_ADDR_P1, coord_word(x1, y1), resp);
        check_equal(resp, OKAY, "P1 write response");
        run_op(raster_pkg::OP_LINE, c);
        shadow_line(x0, y0, x1, y1, c);
    endtask

    task automatic test_reset_and_clear();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(`RASTER_ADDR_STATUS, data, resp);
        check_equal(data, 0, "STATUS after reset");
        check_equal(resp, OKAY, "STATUS read response");
        axi_read(`RASTER_ADDR_P0, data, resp);
        check_equal(data, 0, "P0 after reset");
        axi_read(`RASTER_ADDR_P1, data, resp);
        check_equal(data, 0, "P1 after reset");
        axi_read(`RASTER_ADDR_CTRL, data, resp);
        check_equal(data, 0, "CTRL after reset");
        clear_col = 4'($urandom_range(15, 0));
        run_op(raster_pkg::OP_CLEAR, clear_col);
        fill_shadow(clear_col);
        capture_frame();
        compare_frame("clear");
    endtask

    task automatic test_straight_lines();
        draw_line(20, 3, 4, 3);                         // reversed ends
        draw_line(0, 12, 31, 12);
        draw_line(10, 13, 10, 2);
        draw_line(25, 1, 25, 14);
        capture_frame();
        compare_frame("straight lines");
    endtask

    task automatic test_diagonals();
        draw_line(2, 1, 12, 11);
        draw_line(20, 14, 27, 7);                       // y falling
        capture_frame();
        compare_frame("diagonals");
    endtask

    task automatic test_register_access();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(`RASTER_ADDR_P0, coord_word(17, 9), resp);
        axi_write(`RASTER_ADDR_P1, coord_word(3, 14), resp);
        axi_write(`RASTER_ADDR_CTRL, ctrl_word(raster_pkg::OP_NOP, 4'h7), resp);
        axi_read(`RASTER_ADDR_P0, data, resp);
        check_equal(data, coord_word(17, 9), "P0 readback");
        axi_read(`RASTER_ADDR_P1, data, resp);
        check_equal(data, coord_word(3, 14), "P1 readback");
        axi_read(`RASTER_ADDR_CTRL, data, resp);
        check_equal(data, ctrl_word(raster_pkg::OP_NOP, 4'h7), "CTRL readback");
        axi_read(32'h10, data, resp);
        check_equal(data, 0, "unmapped read data");
        check_equal(resp, SLVERR, "unmapped read response");
        axi_write(32'h20, 32'hFFFF_FFFF, resp);
        check_equal(resp, SLVERR, "unmapped write response");
    endtask

    task automatic test_clip_right();
        draw_line(28, 5, 40, 5);
        capture_frame();
        compare_frame("clipped line");
    endtask

    task automatic test_busy_reject();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(`RASTER_ADDR_P0, coord_word(0, 0), resp);
        axi_write(`RASTER_ADDR_P1, coord_word(31, 15), resp);
        clear_col = other_colour(clear_col);
        axi_write(`RASTER_ADDR_CTRL, ctrl_word(raster_pkg::OP_CLEAR, clear_col), resp);
        check_equal(resp, OKAY, "clear start response");
        axi_write(`RASTER_ADDR_CTRL, ctrl_word(raster_pkg::OP_LINE, ~clear_col), resp);
        check_equal(resp, SLVERR, "CTRL write while busy");
        wait_idle();
        axi_read(`RASTER_ADDR_CTRL, data, resp);
        check_equal(data, ctrl_word(raster_pkg::OP_CLEAR, clear_col), "CTRL after reject");
        fill_shadow(clear_col);
        capture_frame();
        compare_frame("rejected line");
        axi_write(`RASTER_ADDR_CTRL, ctrl_word(raster_pkg::OP_NOP, ~clear_col), resp);
        check_equal(resp, OKAY, "NOP write response");
        axi_read(`RASTER_ADDR_STATUS, data, resp);
        check_equal(data, 0, "STATUS after NOP");
        capture_frame();
        compare_frame("after NOP");
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        void'($urandom(25674));
        arst_n  = 1'b0;
        awaddr  = '0;
        wdata   = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(posedge clk_pix);
        #2;
        arst_n = 1'b1;

        verify_sync_timing();
        test_reset_and_clear();
        test_straight_lines();
        test_diagonals();
        test_register_access();
        test_busy_reject();
        test_clip_right();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/raster_sva.sv ====
/* concurrent assertions on the AXI4-Lite response channels and the
   pixel stream, bound into the top level */
`timescale 1ns/100ps
`default_nettype none

module raster_sva (
    input logic        clk_pix,
    input logic        arst_n,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        pix_de,
    input logic        pix_hsync
);

    // write response held until taken
    assert property (@(posedge clk_pix) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

    // read data held until taken
    assert property (@(posedge clk_pix) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read data dropped or changed before rready");

    assert property (@(posedge clk_pix) disable iff (!arst_n)
        pix_hsync |-> !pix_de)
        else $error("data enable high during hsync");

endmodule

bind line_raster_top raster_sva i_sva (
    .clk_pix   (clk_pix),
    .arst_n    (arst_n),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .pix_de    (pix_de),
    .pix_hsync (pix_hsync)
);

`default_nettype wire

// ==== source/line_raster_top.sv ====
/* line raster top level: register decode, raster engine, scan timing
   and frame store */
`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module line_raster_top (
    input  logic                      clk_pix,
    input  logic                      arst_n,
    input  logic [31:0]               awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [31:0]               araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`RASTER_CIDXW-1:0]  pix_cidx,
    output logic                      pix_de,
    output logic                      pix_hsync,
    output logic                      pix_vsync
);

    raster_cmd_if cmd_bus ();
    pix_wr_if     wr_bus ();
    scan_if       scan_bus ();

    raster_reg_decode i_decode (
        .clk_pix, .arst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .cmd     (cmd_bus.decode)
    );

    raster_engine i_engine (.clk_pix, .arst_n, .cmd(cmd_bus.engine), .wr(wr_bus.source));

    scan_timing i_scan (.clk_pix, .arst_n, .scan(scan_bus.source));

    frame_store i_store (
        .clk_pix, .arst_n,
        .wr      (wr_bus.sink),
        .scan    (scan_bus.sink),
        .pix_cidx, .pix_de, .pix_hsync, .pix_vsync
    );

endmodule

`default_nettype wire

// ==== source/frame_store.sv ====
/* colour-index frame memory with a clipped write port and a registered
   raster-order read port */
`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module frame_store (
    input  logic                      clk_pix,
    input  logic                      arst_n,
    pix_wr_if.sink                    wr,
    scan_if.sink                      scan,
    output logic [`RASTER_CIDXW-1:0]  pix_cidx,
    output logic                      pix_de,
    output logic                      pix_hsync,
    output logic                      pix_vsync
);

    localparam int XW    = $clog2(`RASTER_WIDTH);
    localparam int YW    = $clog2(`RASTER_HEIGHT);
    localparam int DEPTH = `RASTER_WIDTH * `RASTER_HEIGHT;

    logic [`RASTER_CIDXW-1:0] mem [DEPTH];
    logic [`RASTER_CIDXW-1:0] rd_data;
    logic [XW+YW-1:0]         wr_addr, rd_addr;
    logic                     wr_in;

    // coordinates outside the active area never reach the memory
    assign wr_in   = wr.we && (wr.x >= 0) && (wr.x < `RASTER_WIDTH) &&
                     (wr.y >= 0) && (wr.y < `RASTER_HEIGHT);
    assign wr_addr = {wr.y[YW-1:0], wr.x[XW-1:0]};      // y*32 + x
    assign rd_addr = {scan.sy[YW-1:0], scan.sx[XW-1:0]};
    assign pix_cidx = pix_de ? rd_data : '0;

    always_ff @(posedge clk_pix) begin
        if (wr_in)
            mem[wr_addr] <= wr.cidx;
        rd_data <= mem[rd_addr];
    end

    // controls delayed one cycle to line up with rd_data
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pix_de    <= 1'b0;
            pix_hsync <= 1'b0;
            pix_vsync <= 1'b0;
        end else begin
            pix_de    <= scan.de;
            pix_hsync <= scan.hsync;
            pix_vsync <= scan.vsync;
        end
    end

endmodule

`default_nettype wire

// ==== source/scan_timing.sv ====
/* horizontal and vertical scan counters with data enable, syncs and
   the frame start pulse */
`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module scan_timing (
    input  logic   clk_pix,
    input  logic   arst_n,
    scan_if.source scan
);

    localparam int CW = `RASTER_CORDW;

    logic [CW-1:0] sx, sy;

    assign scan.sx    = sx;
    assign scan.sy    = sy;
    assign scan.de    = (sx < CW'(`RASTER_WIDTH)) && (sy < CW'(`RASTER_HEIGHT));
    assign scan.hsync = (sx >= CW'(`RASTER_HS_START)) && (sx <= CW'(`RASTER_HS_END));
    assign scan.vsync = (sy == CW'(`RASTER_VS_LINE));
    assign scan.frame = (sx == '0) && (sy == '0);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == CW'(`RASTER_H_TOTAL - 1)) begin
            sx <= '0;
            sy <= (sy == CW'(`RASTER_V_TOTAL - 1)) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/raster_engine.sv ====
/* raster engine FSM: full-frame clear and Bresenham line, one pixel
   write per clock */
`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module raster_engine (
    input  logic         clk_pix,
    input  logic         arst_n,
    raster_cmd_if.engine cmd,
    pix_wr_if.source     wr
);

    localparam int CW = `RASTER_CORDW;
    localparam int EW = `RASTER_CORDW + 3;              // room for 2*err
    localparam logic signed [CW-1:0] ONE    = 1;
    localparam logic signed [CW-1:0] X_LAST = CW'(`RASTER_WIDTH - 1);
    localparam logic signed [CW-1:0] Y_LAST = CW'(`RASTER_HEIGHT - 1);

    typedef enum logic [1:0] {IDLE, CLEAR, LINE, DONE} state_e;

    state_e                   state;
    logic signed [CW-1:0]     x, y, xe, ye;
    logic [`RASTER_CIDXW-1:0] col;
    logic                     x_neg, y_neg;
    logic signed [EW-1:0]     dx, dy, err, e2, err_next;
    logic signed [EW-1:0]     diff_x, diff_y, abs_dx, abs_dy;
    logic                     step_x, step_y;

    assign cmd.busy = (state != IDLE);
    assign wr.we    = (state == CLEAR) || (state == LINE);
    assign wr.x     = x;
    assign wr.y     = y;
    assign wr.cidx  = col;

    always_comb begin
        diff_x   = EW'(cmd.x1) - EW'(cmd.x0);
        diff_y   = EW'(cmd.y1) - EW'(cmd.y0);
        abs_dx   = (diff_x < 0) ? -diff_x : diff_x;
        abs_dy   = (diff_y < 0) ? -diff_y : diff_y;
        e2       = err <<< 1;
        step_x   = (e2 >= dy);
        step_y   = (e2 <= dx);
        err_next = err;
        if (step_x)
            err_next = err_next + dy;
        if (step_y)
            err_next = err_next + dx;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd.start && cmd.op == raster_pkg::OP_CLEAR)
                        state <= CLEAR;
                    else if (cmd.start && cmd.op == raster_pkg::OP_LINE)
                        state <= LINE;
                end
                CLEAR:   if (x == X_LAST && y == Y_LAST) state <= DONE;
                LINE:    if (x == xe && y == ye) state <= DONE;     // both ends drawn
                default: state <= IDLE;                             // DONE
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == IDLE && cmd.start) begin
            col   <= cmd.cidx;
            x     <= (cmd.op == raster_pkg::OP_CLEAR) ? '0 : cmd.x0;
            y     <= (cmd.op == raster_pkg::OP_CLEAR) ? '0 : cmd.y0;
            xe    <= cmd.x1;
            ye    <= cmd.y1;
            x_neg <= diff_x < 0;
            y_neg <= diff_y < 0;
            dx    <= abs_dx;
            dy    <= -abs_dy;
            err   <= abs_dx - abs_dy;
        end else if (state == CLEAR) begin
            if (x == X_LAST) begin
                x <= '0;
                y <= y + ONE;
            end else begin
                x <= x + ONE;
            end
        end else if (state == LINE) begin
            if (step_x)
                x <= x_neg ? x - ONE : x + ONE;
            if (step_y)
                y <= y_neg ? y - ONE : y + ONE;
            err <= err_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/raster_reg_decode.sv ====
/* AXI4-Lite register slave holding the endpoints and the control word,
   and launching raster operations */
`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

module raster_reg_decode (
    input  logic        clk_pix,
    input  logic        arst_n,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    raster_cmd_if.decode cmd
);

    raster_pkg::reg_word_u p0_q, p1_q, ctrl_q;
    raster_pkg::reg_word_u wr_word;
    logic                  wr_go, rd_go;
    logic                  wr_err, rd_err, wr_is_op;
    logic [31:0]           rd_word;

    function automatic logic [31:0] coord_view(input raster_pkg::reg_word_u w);
        raster_pkg::reg_word_u r;
        r = '0;
        r.coord.y = w.coord.y;
        r.coord.x = w.coord.x;
        return r;
    endfunction

    function automatic logic [31:0] ctrl_view(input raster_pkg::reg_word_u w);
        raster_pkg::reg_word_u r;
        r = '0;
        r.ctrl.op   = w.ctrl.op;
        r.ctrl.cidx = w.ctrl.cidx;
        return r;
    endfunction

    assign wr_word  = wdata;
    assign wr_go    = awvalid && wvalid && !bvalid;   // aw and w taken together
    assign awready  = wr_go;
    assign wready   = wr_go;
    assign rd_go    = arvalid && !rvalid;
    assign arready  = rd_go;
    assign wr_is_op = (wr_word.ctrl.op == raster_pkg::OP_LINE) ||
                      (wr_word.ctrl.op == raster_pkg::OP_CLEAR);

    // launch straight from the write handshake
    assign cmd.start = wr_go && (awaddr == `RASTER_ADDR_CTRL) && wr_is_op && !cmd.busy;
    assign cmd.op    = wr_word.ctrl.op;
    assign cmd.cidx  = wr_word.ctrl.cidx;
    assign cmd.x0    = p0_q.coord.x;
    assign cmd.y0    = p0_q.coord.y;
    assign cmd.x1    = p1_q.coord.x;
    assign cmd.y1    = p1_q.coord.y;

    always_comb begin
        case (awaddr)
            `RASTER_ADDR_P0,
            `RASTER_ADDR_P1:   wr_err = 1'b0;
            `RASTER_ADDR_CTRL: wr_err = cmd.busy;           // engine still running
            default:           wr_err = 1'b1;
        endcase
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (araddr)
            `RASTER_ADDR_P0:     rd_word = coord_view(p0_q);
            `RASTER_ADDR_P1:     rd_word = coord_view(p1_q);
            `RASTER_ADDR_CTRL:   rd_word = ctrl_view(ctrl_q);
            `RASTER_ADDR_STATUS: rd_word = {31'b0, cmd.busy};
            default:             rd_err  = 1'b1;
        endcase
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            p0_q   <= '0;
            p1_q   <= '0;
            ctrl_q <= '0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go && !wr_err) begin
                case (awaddr)
                    `RASTER_ADDR_P0:   p0_q   <= wr_word;
                    `RASTER_ADDR_P1:   p1_q   <= wr_word;
                    default:           ctrl_q <= wr_word;
                endcase
            end
            if (wr_go)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_go)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // response payload, held while valid is up
    always_ff @(posedge clk_pix) begin
        if (wr_go)
            bresp <= wr_err ? raster_pkg::RESP_SLVERR : raster_pkg::RESP_OKAY;
        if (rd_go) begin
            rdata <= rd_word;
            rresp <= rd_err ? raster_pkg::RESP_SLVERR : raster_pkg::RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== source/raster_if.sv ====
/* raster_cmd_if, pix_wr_if and scan_if with their modports */
`timescale 1ns/100ps
`default_nettype none

`include "raster_consts.svh"

interface raster_cmd_if;
    logic                             start;    // one-cycle launch
    raster_pkg::raster_op_e           op;
    logic [`RASTER_CIDXW-1:0]         cidx;
    logic signed [`RASTER_CORDW-1:0]  x0, y0, x1, y1;
    logic                             busy;

    modport decode (output start, op, cidx, x0, y0, x1, y1, input busy);
    modport engine (input start, op, cidx, x0, y0, x1, y1, output busy);
endinterface

interface pix_wr_if;
    logic                             we;       // no back-pressure
    logic signed [`RASTER_CORDW-1:0]  x, y;
    logic [`RASTER_CIDXW-1:0]         cidx;

    modport source (output we, x, y, cidx);
    modport sink   (input we, x, y, cidx);
endinterface

interface scan_if;
    logic [`RASTER_CORDW-1:0]         sx, sy;   // scan position
    logic                             de;
    logic                             hsync, vsync;
    logic                             frame;    // pulse at (0,0)

    modport source (output sx, sy, de, hsync, vsync, frame);
    modport sink   (input sx, sy, de, hsync, vsync, frame);
endinterface

`default_nettype wire

// ==== source/raster_pkg.sv ====
/* operation codes, register word views and AXI response codes */
`default_nettype none

`include "raster_consts.svh"

package raster_pkg;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LINE  = 2'd1,
        OP_CLEAR = 2'd2
    } raster_op_e;

    typedef struct packed {
        logic [31-2*`RASTER_CORDW:0]       pad;
        logic signed [`RASTER_CORDW-1:0]   y;
        logic signed [`RASTER_CORDW-1:0]   x;
    } coord_t;

    typedef struct packed {
        logic [31-2-`RASTER_CIDXW:0]       pad;
        raster_op_e                        op;
        logic [`RASTER_CIDXW-1:0]          cidx;
    } ctrl_t;

    // P0/P1 use the coord view, CTRL the ctrl view
    typedef union packed {
        coord_t coord;
        ctrl_t  ctrl;
    } reg_word_u;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

endpackage

`default_nettype wire

// ==== source/raster_consts.svh ====
/* frame geometry, scan timing, data widths and the register map
   of the line raster subsystem */
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

`define RASTER_WIDTH       32           // active pixels per line
`define RASTER_HEIGHT      16           // active lines per frame

`define RASTER_H_TOTAL     40           // columns incl. blanking
`define RASTER_V_TOTAL     20           // rows incl. blanking
`define RASTER_HS_START    34           // first hsync column
`define RASTER_HS_END      35           // last hsync column
`define RASTER_VS_LINE     17           // vsync row

`define RASTER_CORDW       8            // signed coordinate width
`define RASTER_CIDXW       4            // colour index width

`define RASTER_ADDR_P0     32'h0000_0000
`define RASTER_ADDR_P1     32'h0000_0004
`define RASTER_ADDR_CTRL   32'h0000_0008
`define RASTER_ADDR_STATUS 32'h0000_000C

`endif
